/* hw/bscanPkg.sv */
// Shared lengths and types for the I/O port boundary-scan block.
// Both chains must have the same length; one scan shifts scanLen bits.
// Words travel LSB first on both serial paths.

package bscanPkg;

	////////////////////////////////////////////////////////////
	// Chain geometry.
	////////////////////////////////////////////////////////////

	// Output pins and bits per output cell.
	localparam int numOutPins = 4;
	localparam int outCellBits = 3;

	// Input pins, one capture bit each.
	localparam int numInPins = 12;

	// Shift count per scan.
	localparam int scanLen = numOutPins * outCellBits;

	// Width of the shift counter.
	localparam int scanCntW = $clog2(scanLen);

	// Bit offsets inside one output cell.
	localparam int cellOutBit = 0;
	localparam int cellTriBit = 1;
	localparam int cellInpBit = 2;

	////////////////////////////////////////////////////////////
	// Command and response.
	////////////////////////////////////////////////////////////

	// Command opcodes; value 3 is unused.
	typedef enum logic [1:0] {
		OP_SCAN  = 2'd0,
		OP_ALLOW = 2'd1,
		OP_BLOCK = 2'd2
	} scanOpT;

	// Opcode plus the word shifted into the output chain.
	typedef struct packed {
		scanOpT op;
		logic [scanLen-1:0] outData;
	} scanCmdT;

	// Words shifted out of both chains.
	typedef struct packed {
		logic [scanLen-1:0] outWord;
		logic [scanLen-1:0] inWord;
	} scanRspT;

endpackage

/* hw/bscanOutChain.sv */
// Output-pin boundary-scan cells, three bits per pin.
// Cells drive directly from their shift bits; there is no update stage.
// Shift order per cell is serial in, inp, tri, out, then on to the next cell.
// The inp bit samples the driven pad level through one synchronizer flop.

`timescale 1ns/1ps

module bscanOutChain (
	input  logic clk,
	input  logic arstN,
	input  logic scanShift,
	input  logic allowOverride,
	input  logic outSerIn,
	input  logic [bscanPkg::numOutPins-1:0] coreOut,
	output logic [bscanPkg::numOutPins-1:0] padOut,
	output logic outSerOut
);

	import bscanPkg::*;

	////////////////////////////////////////////////////////////
	// Signals.
	////////////////////////////////////////////////////////////

	// All cell bits as one word; cell i sits at bits 3i..3i+2.
	logic [scanLen-1:0] chainQ;

	// Word after one shift step.
	logic [scanLen-1:0] chainShift;

	// Pad sample, first half of the synchronizer.
	logic [numOutPins-1:0] padSync;

	// Per-pin override decision.
	logic [numOutPins-1:0] overridePin;

	////////////////////////////////////////////////////////////
	// Pad drive.
	////////////////////////////////////////////////////////////

	// Override needs allowance, no shifting and tri set.
	// Otherwise the core owns the pin.
	always_comb begin
		for (int i = 0; i < numOutPins; i++) begin
			overridePin[i] = allowOverride & ~scanShift
				& chainQ[outCellBits*i + cellTriBit];
			padOut[i] = overridePin[i] ? chainQ[outCellBits*i + cellOutBit] : coreOut[i];
		end
	end

	// Resample what is actually driven.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			padSync <= '0;
		end else begin
			padSync <= padOut;
		end
	end

	////////////////////////////////////////////////////////////
	// Shift and capture.
	////////////////////////////////////////////////////////////

	// Data enters at the top, leaves at cell 0's out bit.
	assign chainShift = {outSerIn, chainQ[scanLen-1:1]};
	assign outSerOut = chainQ[0];

	// While idle only inp bits load; out and tri hold.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			chainQ <= '0;
		end else if (scanShift) begin
			chainQ <= chainShift;
		end else begin
			for (int i = 0; i < numOutPins; i++) begin
				chainQ[outCellBits*i + cellInpBit] <= padSync[i];
			end
		end
	end

endmodule

/* hw/bscanInChain.sv */
// Input-pin capture chain, one bit per pad.
// Pads reach the core directly; this chain only observes them.
// Zeros shift in at the top, so the chain reads back as zero after a scan
// until the next idle cycle recaptures.

`timescale 1ns/1ps

module bscanInChain (
	input  logic clk,
	input  logic arstN,
	input  logic scanShift,
	input  logic [bscanPkg::numInPins-1:0] padIn,
	output logic inSerOut
);

	import bscanPkg::*;

	////////////////////////////////////////////////////////////
	// Signals.
	////////////////////////////////////////////////////////////

	// First synchronizer stage.
	logic [numInPins-1:0] padSync;

	// Capture and shift bits, bit k for pad k.
	logic [numInPins-1:0] capQ;

	////////////////////////////////////////////////////////////
	// Synchronize.
	////////////////////////////////////////////////////////////

	// Pads are asynchronous to clk.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			padSync <= '0;
		end else begin
			padSync <= padIn;
		end
	end

	////////////////////////////////////////////////////////////
	// Capture or shift.
	////////////////////////////////////////////////////////////

	// Second stage doubles as the capture bit.
	// Shifting moves toward bit 0.
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			capQ <= '0;
		end else if (scanShift) begin
			capQ <= {1'b0, capQ[numInPins-1:1]};
		end else begin
			capQ <= padSync;
		end
	end

	// LSB leaves first.
	assign inSerOut = capQ[0];

endmodule

/* hw/scanSequencer.sv */
// Command-driven scan sequencer for both boundary-scan chains.
// One command in flight; a new one waits until the response is taken.
// A scan shifts scanLen bits LSB first; the response word bit k is the
// bit that left the chain on shift cycle k.
// Unused opcode 3 answers with a zero response and changes nothing.

`timescale 1ns/1ps

module scanSequencer (
	input  logic clk,
	input  logic arstN,
	input  logic cmdValid,
	output logic cmdReady,
	input  bscanPkg::scanCmdT cmd,
	output logic rspValid,
	input  logic rspReady,
	output bscanPkg::scanRspT rsp,
	output logic scanShift,
	output logic allowOverride,
	output logic outSerIn,
	input  logic outSerOut,
	input  logic inSerOut
);

	import bscanPkg::*;

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		RESPOND
	} seqStateT;

	seqStateT state;
	logic cmdAccept;
	logic lastShift;
	logic [scanCntW-1:0] shiftCnt;

	// Word still to be shifted out to the output chain.
	logic [scanLen-1:0] dataQ;

	// Collected serial outputs.
	logic [scanLen-1:0] outRspQ;
	logic [scanLen-1:0] inRspQ;

	////////////////////////////////////////////////////////////
	// Handshakes and chain controls.
	////////////////////////////////////////////////////////////

	// Idle means no command running and no response held.
	assign cmdReady = (state == IDLE);
	assign cmdAccept = cmdValid & cmdReady;
	assign rspValid = (state == RESPOND);
	assign scanShift = (state == SHIFT);
	assign lastShift = (shiftCnt == scanCntW'(scanLen - 1));
	assign outSerIn = dataQ[0];

	////////////////////////////////////////////////////////////
	// Control FSM.
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			shiftCnt <= '0;
			allowOverride <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (cmdAccept) begin
						case (cmd.op)
							OP_SCAN: begin
								state <= SHIFT;
								shiftCnt <= '0;
							end
							OP_ALLOW: begin
								allowOverride <= 1'b1;
								state <= RESPOND;
							end
							OP_BLOCK: begin
								allowOverride <= 1'b0;
								state <= RESPOND;
							end
							default: state <= RESPOND;
						endcase
					end
				end
				SHIFT: begin
					// Exactly scanLen shift cycles.
					shiftCnt <= shiftCnt + 1'b1;
					if (lastShift) begin
						state <= RESPOND;
					end
				end
				RESPOND: begin
					if (rspReady) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Shift datapath.
	////////////////////////////////////////////////////////////

	// Cleared on accept so non-scan commands answer zero.
	// First bit out ends up at bit 0.
	always_ff @(posedge clk) begin
		if (cmdAccept) begin
			dataQ <= cmd.outData;
			outRspQ <= '0;
			inRspQ <= '0;
		end else if (scanShift) begin
			dataQ <= dataQ >> 1;
			outRspQ <= {outSerOut, outRspQ[scanLen-1:1]};
			inRspQ <= {inSerOut, inRspQ[scanLen-1:1]};
		end
	end

	// Combine both chains into one response.
	always_comb begin
		rsp.outWord = outRspQ;
		rsp.inWord = inRspQ;
	end

endmodule

/* hw/bscanTop.sv */
// Boundary-scan block for the controller's I/O port.
// Output pins pass through three-bit scan cells; input pins are only observed.
// Both chains shift together under one command-driven sequencer.
// Single clock domain; pads are resynchronized inside the chains.

`timescale 1ns/1ps

module bscanTop (
	input  logic clk,
	input  logic arstN,
	input  logic cmdValid,
	output logic cmdReady,
	input  bscanPkg::scanCmdT cmd,
	output logic rspValid,
	input  logic rspReady,
	output bscanPkg::scanRspT rsp,
	input  logic [bscanPkg::numOutPins-1:0] coreOut,
	output logic [bscanPkg::numOutPins-1:0] padOut,
	input  logic [bscanPkg::numInPins-1:0] padIn
);

	// Shared chain controls.
	logic scanShift;
	logic allowOverride;

	// Serial paths to and from the chains.
	logic outSerIn;
	logic outSerOut;
	logic inSerOut;

	////////////////////////////////////////////////////////////
	// Chains.
	////////////////////////////////////////////////////////////

	bscanOutChain uOutChain (
		.clk(clk),
		.arstN(arstN),
		.scanShift(scanShift),
		.allowOverride(allowOverride),
		.outSerIn(outSerIn),
		.coreOut(coreOut),
		.padOut(padOut),
		.outSerOut(outSerOut)
	);

	bscanInChain uInChain (
		.clk(clk),
		.arstN(arstN),
		.scanShift(scanShift),
		.padIn(padIn),
		.inSerOut(inSerOut)
	);

	// Sequencer.
	scanSequencer uSequencer (
		.clk(clk),
		.arstN(arstN),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmd(cmd),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.rsp(rsp),
		.scanShift(scanShift),
		.allowOverride(allowOverride),
		.outSerIn(outSerIn),
		.outSerOut(outSerOut),
		.inSerOut(inSerOut)
	);

endmodule

/* testbench/tbBscanTop.sv */
// Testbench for the boundary-scan block with random commands from a fixed seed.
// Inputs change and outputs are sampled on the falling clock edge.
// Pins change only while idle and are held 3 cycles before each command.

`timescale 1ns/1ps

module tbBscanTop;

	import bscanPkg::*;

	localparam int numCmds = 200;
	localparam int timeoutCycles = numCmds * 40;

	logic clk;
	logic arstN;
	logic cmdValid;
	logic cmdReady;
	scanCmdT cmd;
	logic rspValid;
	logic rspReady;
	scanRspT rsp;
	logic [numOutPins-1:0] coreOut;
	logic [numOutPins-1:0] padOut;
	logic [numInPins-1:0] padIn;

	// Last scanned word and override flag of the model.
	logic [scanLen-1:0] lastData;
	logic modelAllow;

	integer seed;
	logic [31:0] rnd;
	int errCount;
	int cycleCnt = 0;
	string testName;

	bscanTop DUT (
		.clk(clk),
		.arstN(arstN),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmd(cmd),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.rsp(rsp),
		.coreOut(coreOut),
		.padOut(padOut),
		.padIn(padIn)
	);

	////////////////////////////////////////////////////////////
	// Clock and run limit.
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Worst case per command is well under 40 cycles.
	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= timeoutCycles) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycleCnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Model and reporting.
	////////////////////////////////////////////////////////////

	// Cell i drives its out bit when allowed and tri is set.
	function automatic logic [numOutPins-1:0] modelPad(input logic [scanLen-1:0] data,
			input logic allow, input logic [numOutPins-1:0] core);
		logic [numOutPins-1:0] pad;
		for (int i = 0; i < numOutPins; i++) begin
			if (allow && data[3*i+1]) begin
				pad[i] = data[3*i];
			end else begin
				pad[i] = core[i];
			end
		end
		return pad;
	endfunction

	// Out and tri from the last scan, inp from the driven pads.
	function automatic logic [scanLen-1:0] expectedOutWord(input logic [scanLen-1:0] data,
			input logic [numOutPins-1:0] pad);
		logic [scanLen-1:0] word;
		word = data;
		for (int i = 0; i < numOutPins; i++) begin
			word[3*i+2] = pad[i];
		end
		return word;
	endfunction

	task automatic reportMismatch(input string what, input logic [23:0] expVal,
			input logic [23:0] actVal);
		$display("Mismatch %s %s expected 0x%h actual 0x%h", testName, what, expVal, actVal);
		errCount++;
	endtask

	task automatic reportFailure(input string what);
		$display("Error in %s: %s", testName, what);
		errCount++;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and checks.
	////////////////////////////////////////////////////////////

	initial begin
		int respCycles;
		int expCycles;
		int errBefore;
		logic [1:0] delay;
		logic [numOutPins-1:0] expPad;
		scanRspT expRsp;
		scanRspT heldRsp;
		scanOpT op;

		seed = 32'hfb0b_809b;
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmd = '0;
		rspReady = 1'b0;
		coreOut = '0;
		padIn = '0;
		lastData = '0;
		modelAllow = 1'b0;
		errCount = 0;

		repeat (10) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		rnd = $random(seed);
		coreOut = rnd[3:0];
		@(negedge clk);

		// Idle state right after reset.
		testName = "reset";
		if (cmdReady !== 1'b1 || rspValid !== 1'b0) begin
			reportFailure("cmdReady should be high and rspValid low after reset");
		end
		if (padOut !== coreOut) begin
			reportMismatch("padOut", {20'h0, coreOut}, {20'h0, padOut});
		end
		$display("%s %s", testName, (errCount == 0) ? "ok" : "failed");

		for (int n = 0; n < numCmds; n++) begin
			errBefore = errCount;

			// New pin values, then let the synchronizers settle.
			rnd = $random(seed);
			coreOut = rnd[3:0];
			padIn = rnd[15:4];
			repeat (3) @(negedge clk);

			rnd = $random(seed);
			case (rnd[1:0])
				2'd2: op = OP_ALLOW;
				2'd3: op = OP_BLOCK;
				default: op = OP_SCAN;
			endcase
			cmd.op = op;
			cmd.outData = rnd[13:2];
			testName = $sformatf("cmd%0d_%s", n, op.name());

			expPad = modelPad(lastData, modelAllow, coreOut);
			if (padOut !== expPad) begin
				reportMismatch("idle padOut", {20'h0, expPad}, {20'h0, padOut});
			end
			if (op == OP_SCAN) begin
				expRsp.outWord = expectedOutWord(lastData, expPad);
				expRsp.inWord = padIn;
			end else begin
				expRsp = '0;
			end
			if (cmdReady !== 1'b1) begin
				reportFailure("cmdReady is low while the DUT is idle");
			end

			// Accepted on the rising edge in between.
			cmdValid = 1'b1;
			@(negedge clk);
			cmdValid = 1'b0;

			if (op == OP_SCAN) begin
				lastData = cmd.outData;
			end else if (op == OP_ALLOW) begin
				modelAllow = 1'b1;
			end else begin
				modelAllow = 1'b0;
			end
			expPad = modelPad(lastData, modelAllow, coreOut);

			// Count cycles up to the response.
			respCycles = 1;
			while (rspValid !== 1'b1) begin
				if (padOut !== coreOut) begin
					reportMismatch("shift padOut", {20'h0, coreOut}, {20'h0, padOut});
				end
				if (cmdReady !== 1'b0) begin
					reportFailure("cmdReady is high while a scan runs");
				end
				@(negedge clk);
				respCycles++;
			end
			expCycles = (op == OP_SCAN) ? scanLen + 1 : 1;
			if (respCycles != expCycles) begin
				reportMismatch("latency", expCycles[23:0], respCycles[23:0]);
			end
			if (rsp !== expRsp) begin
				reportMismatch("rsp", expRsp, rsp);
			end
			if (padOut !== expPad) begin
				reportMismatch("response padOut", {20'h0, expPad}, {20'h0, padOut});
			end

			// Back-pressure for 0 to 3 cycles.
			heldRsp = rsp;
			rnd = $random(seed);
			delay = rnd[1:0];
			repeat (delay) begin
				@(negedge clk);
				if (rspValid !== 1'b1 || rsp !== heldRsp) begin
					reportFailure("response changed while rspReady was low");
				end
				if (cmdReady !== 1'b0) begin
					reportFailure("cmdReady is high while a response is held");
				end
			end
			rspReady = 1'b1;
			@(negedge clk);
			rspReady = 1'b0;
			if (rspValid !== 1'b0 || cmdReady !== 1'b1) begin
				reportFailure("DUT did not return to idle after the response was taken");
			end

			$display("%s %s", testName, (errCount == errBefore) ? "ok" : "failed");
		end

		$display("Tests run %0d, failed checks %0d", numCmds + 1, errCount);
		if (errCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* all.f */
hw/bscanPkg.sv
hw/bscanOutChain.sv
hw/bscanInChain.sv
hw/scanSequencer.sv
hw/bscanTop.sv
testbench/tbBscanTop.sv

/* run.sh */
#!/bin/sh
# Builds the boundary-scan testbench with Verilator and runs it.
# Exits non-zero on a build error, a simulator error or a failed test.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tbBscanTop \
	--Mdir obj_dir -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
